//--- tb.f
source/cfreq_pkg.sv
source/iq_interleave.sv
source/isqrt.sv
source/complex_freq.sv
source/freq_monitor_top.sv
verif/tb_clk_gen.sv
verif/tb_freq_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frequency monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f tb.f \
	--top-module tb_freq_monitor -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1

//--- verif/tb_freq_monitor.sv
`timescale 1ns/10ps

module tb_freq_monitor;

	localparam int REFCNT_W    = 4;
	localparam int WIN_LEN     = 1 << REFCNT_W;
	localparam int UPD_LAT     = 23;   // Closing pair to updated
	localparam int UPD_TIMEOUT = 2000;
	localparam int MODE_RANDOM = 0;
	localparam int MODE_CCW    = 1;
	localparam int MODE_CW     = 2;
	localparam int MODE_JUMP   = 3;    // Counterclockwise plus one jump of two quadrants

	logic                       clk;
	logic                       rst_n;
	logic                       reset_req;
	cfreq_pkg::sample_t         i_data;
	cfreq_pkg::sample_t         q_data;
	logic                       iq_valid;
	logic signed [REFCNT_W-1:0] freq;
	logic                       freq_valid;
	cfreq_pkg::amp_t            amp_max;
	cfreq_pkg::amp_t            amp_min;
	logic                       updated;
	logic                       timing_err;

	int    errors;
	string test_name;
	int    phase_q;   // Geometric quadrant of the phasor where 0 means I>=0 and Q>=0
	int    cap_freq;  // Last reported window
	int    cap_valid;
	int    ccw_freq;

	// Reference model state
	int m_count;
	int m_quad_prev;
	int m_quad_cnt;
	int m_invalid;
	int m_dev_max;
	int m_dev_min;
	bit m_close;
	int exp_freq;
	int exp_valid;
	int exp_max;
	int exp_min;

	tb_clk_gen i_tb_clk_gen (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

	freq_monitor_top #(
		.refcnt_w (REFCNT_W)
	) i_freq_monitor_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_data     (i_data),
		.q_data     (q_data),
		.iq_valid   (iq_valid),
		.freq       (freq),
		.freq_valid (freq_valid),
		.amp_max    (amp_max),
		.amp_min    (amp_min),
		.updated    (updated),
		.timing_err (timing_err)
	);

	task automatic report_mismatch(input string field, input int exp_val, input int act_val);
		$display("FAIL %s %s expected %0d actual %0d", test_name, field, exp_val, act_val);
		errors++;
	endtask

	// Largest y with y*y <= x found by bisection
	function automatic int root_by_search(input longint x);
		longint lo;
		longint hi;
		longint mid;
		lo = 0;
		hi = longint'(1) << cfreq_pkg::AMP_W;
		while (hi - lo > 1) begin
			mid = (lo + hi) / 2;
			if (mid * mid <= x) lo = mid;
			else                hi = mid;
		end
		return int'(lo);
	endfunction

	// Code is sign I in the upper bit, sign I xor sign Q in the lower bit
	function automatic int quadrant_code(input cfreq_pkg::sample_t i_val,
		input cfreq_pkg::sample_t q_val);
		int s_i;
		int s_q;
		s_i = (i_val < 0) ? 1 : 0;
		s_q = (q_val < 0) ? 1 : 0;
		return 2 * s_i + (s_i ^ s_q);
	endfunction

	task automatic model_reset();
		m_count     = 0;
		m_quad_prev = 0;
		m_quad_cnt  = 0;
		m_invalid   = 0;
		m_dev_max   = 0;
		m_dev_min   = (1 << cfreq_pkg::AMP_W) - 1;
		m_close     = 1'b0;
	endtask

	task automatic model_sample(input cfreq_pkg::sample_t i_val, input cfreq_pkg::sample_t q_val);
		longint                     sq;
		int                         root;
		int                         quad;
		int                         step;
		logic [REFCNT_W:0]          cnt_bits;
		logic signed [REFCNT_W-1:0] f_bits;
		sq = longint'(i_val) * longint'(i_val) + longint'(q_val) * longint'(q_val);
		sq = sq % (longint'(1) << cfreq_pkg::SQ_W); // Sum is truncated before the root
		root = root_by_search(sq);
		quad = quadrant_code(i_val, q_val);
		step = (quad - m_quad_prev + 4) % 4;
		m_quad_prev = quad;
		if (step == 1)      m_quad_cnt++;
		else if (step == 3) m_quad_cnt--;
		else if (step == 2) m_invalid = 1;
		m_count++;
		m_close = (m_count >= 3) && ((m_count - 3) % WIN_LEN == 0);
		if (m_close) begin
			cnt_bits   = m_quad_cnt[REFCNT_W:0];
			f_bits     = cnt_bits[REFCNT_W:1];
			exp_freq   = int'(f_bits);
			exp_valid  = 1 - m_invalid;
			exp_max    = m_dev_max;
			exp_min    = m_dev_min;
			m_quad_cnt = 0;
			m_invalid  = 0;
			m_dev_max  = root; // Closing sample opens the next window
			m_dev_min  = root;
		end else begin
			if (root > m_dev_max) m_dev_max = root;
			if (root < m_dev_min) m_dev_min = root;
		end
	endtask

	task automatic random_pair(output cfreq_pkg::sample_t i_val, output cfreq_pkg::sample_t q_val);
		i_val = cfreq_pkg::sample_t'($urandom);
		q_val = cfreq_pkg::sample_t'($urandom);
	endtask

	task automatic make_point(input int g, output cfreq_pkg::sample_t i_val,
		output cfreq_pkg::sample_t q_val);
		int mi;
		int mq;
		mi = 1 + int'($urandom % 65536);
		mq = 1 + int'($urandom % 65536);
		i_val = cfreq_pkg::sample_t'((g == 1 || g == 2) ? -mi : mi);
		q_val = cfreq_pkg::sample_t'((g >= 2) ? -mq : mq);
	endtask

	// Called on a falling edge and returns on one
	task automatic send_sample(input cfreq_pkg::sample_t i_val, input cfreq_pkg::sample_t q_val,
		input int gap);
		int k;
		bit seen;
		model_sample(i_val, q_val);
		i_data   = i_val;
		q_data   = q_val;
		iq_valid = 1'b1;
		k        = 0;
		seen     = 1'b0;
		while (k < gap || (m_close && !seen && k < UPD_TIMEOUT)) begin
			@(negedge clk);
			k++;
			iq_valid = 1'b0;
			if (timing_err) begin
				$display("%s: timing_err pulsed with pairs spaced %0d cycles", test_name, gap);
				errors++;
			end
			if (updated && (!m_close || seen)) begin
				$display("%s: updated pulsed without a closing sample, sample %0d", test_name,
					m_count);
				errors++;
			end else if (updated) begin
				seen = 1'b1;
				if (k != UPD_LAT) report_mismatch("update_latency", UPD_LAT, k);
				if (int'(freq) != exp_freq) report_mismatch("freq", exp_freq, int'(freq));
				if (int'(freq_valid) != exp_valid)
					report_mismatch("freq_valid", exp_valid, int'(freq_valid));
				if (int'(amp_max) != exp_max) report_mismatch("amp_max", exp_max, int'(amp_max));
				if (int'(amp_min) != exp_min) report_mismatch("amp_min", exp_min, int'(amp_min));
				cap_freq  = int'(freq);
				cap_valid = int'(freq_valid);
			end
		end
		if (m_close && !seen) begin
			$display("%s: updated never pulsed within %0d cycles after sample %0d", test_name,
				UPD_TIMEOUT, m_count);
			errors++;
		end
	endtask

	task automatic run_window(input string name, input int n, input int mode);
		int                 s;
		int                 gap;
		cfreq_pkg::sample_t i_val;
		cfreq_pkg::sample_t q_val;
		test_name = name;
		for (s = 0; s < n; s++) begin
			gap = 22 + int'($urandom % 9);
			if (mode == MODE_RANDOM) begin
				random_pair(i_val, q_val);
			end else begin
				if (s % 2 == 0) phase_q = (phase_q + ((mode == MODE_CW) ? 3 : 1)) % 4;
				if (mode == MODE_JUMP && s == 5) phase_q = (phase_q + 2) % 4;
				make_point(phase_q, i_val, q_val);
			end
			send_sample(i_val, q_val, gap);
		end
	endtask

	task automatic wait_reset_release();
		int k;
		k = 0;
		while (!rst_n && k < 20) begin
			@(negedge clk);
			k++;
		end
		if (!rst_n) begin
			$display("%s: reset was never released", test_name);
			errors++;
		end
	endtask

	task automatic check_reset_state();
		if (updated !== 1'b0)    report_mismatch("updated", 0, int'(updated));
		if (freq_valid !== 1'b0) report_mismatch("freq_valid", 0, int'(freq_valid));
		if (timing_err !== 1'b0) report_mismatch("timing_err", 0, int'(timing_err));
		if (freq !== '0)         report_mismatch("freq", 0, int'(freq));
		if (amp_max !== '0)      report_mismatch("amp_max", 0, int'(amp_max));
		if (amp_min !== '0)      report_mismatch("amp_min", 0, int'(amp_min));
	endtask

	// Second pair only 10 cycles after the first and normal pairs until a report
	task automatic run_overrun();
		int k;
		bit err_seen;
		bit upd_seen;
		test_name = "overrun";
		err_seen  = 1'b0;
		upd_seen  = 1'b0;
		random_pair(i_data, q_data);
		iq_valid = 1'b1;
		k = 0;
		while (!upd_seen && k < UPD_TIMEOUT) begin
			@(negedge clk);
			k++;
			iq_valid = 1'b0;
			if (timing_err) err_seen = 1'b1;
			if (updated)    upd_seen = 1'b1;
			if (!upd_seen && (k == 10 || k % 25 == 0)) begin
				random_pair(i_data, q_data);
				iq_valid = 1'b1;
			end
		end
		if (!upd_seen) begin
			$display("overrun: updated never pulsed within %0d cycles", UPD_TIMEOUT);
			errors++;
		end
		if (!err_seen) begin
			$display("overrun: timing_err did not pulse before updated");
			errors++;
		end
	endtask

	task automatic reset_dut();
		test_name = "reset_again";
		@(negedge clk);
		reset_req <= 1'b1;
		@(negedge clk);
		reset_req <= 1'b0;
		@(negedge clk);
		wait_reset_release();
	endtask

	initial begin
		errors    = 0;
		i_data    = '0;
		q_data    = '0;
		iq_valid  = 1'b0;
		reset_req = 1'b0;
		phase_q   = 0;
		cap_freq  = 0;
		cap_valid = 0;
		test_name = "reset";
		void'($urandom(41));
		model_reset();

		@(negedge clk);
		wait_reset_release();
		check_reset_state();

		run_window("first_window", 3, MODE_RANDOM); // Short window after reset
		repeat (3) run_window("random_window", WIN_LEN, MODE_RANDOM);

		// Second window of each direction starts from a clean step
		run_window("rotate_ccw_lead", WIN_LEN, MODE_CCW);
		run_window("rotate_ccw", WIN_LEN, MODE_CCW);
		ccw_freq = cap_freq;
		if (cap_valid != 1) report_mismatch("freq_valid", 1, cap_valid);
		run_window("rotate_cw_lead", WIN_LEN, MODE_CW);
		run_window("rotate_cw", WIN_LEN, MODE_CW);
		if (cap_valid != 1) report_mismatch("freq_valid", 1, cap_valid);
		if (ccw_freq == 0 || cap_freq != -ccw_freq) report_mismatch("opposite_freq", -ccw_freq,
			cap_freq);

		run_window("jump_window", WIN_LEN, MODE_JUMP);
		if (cap_valid != 0) report_mismatch("freq_valid", 0, cap_valid);
		run_window("clean_after_jump", WIN_LEN, MODE_CCW);
		if (cap_valid != 1) report_mismatch("freq_valid", 1, cap_valid);

		run_overrun();
		reset_dut();
		model_reset();
		check_reset_state();
		run_window("first_window_again", 3, MODE_RANDOM);

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
	input  logic reset_req, // Restarts the reset sequence
	output logic clk,
	output logic rst_n
);

	int rst_cnt = 4; // Rising edges left with reset low

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset changes on the falling edge like every other DUT input
	always @(negedge clk) begin
		if (reset_req)        rst_cnt <= 4;
		else if (rst_cnt > 0) rst_cnt <= rst_cnt - 1;
	end

	assign rst_n = (rst_cnt == 0);

endmodule

//--- source/freq_monitor_top.sv
`timescale 1ns/10ps

module freq_monitor_top #(
	parameter int refcnt_w = cfreq_pkg::REFCNT_W_DEF
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cfreq_pkg::sample_t         i_data,
	input  cfreq_pkg::sample_t         q_data,
	input  logic                       iq_valid,
	output logic signed [refcnt_w-1:0] freq,
	output logic                       freq_valid,
	output cfreq_pkg::amp_t            amp_max,
	output cfreq_pkg::amp_t            amp_min,
	output logic                       updated,
	output logic                       timing_err
);

	cfreq_pkg::sample_t sdata; // Interleaved I/Q stream
	logic               sgate;

	iq_interleave i_iq_interleave (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_data   (i_data),
		.q_data   (q_data),
		.iq_valid (iq_valid),
		.sdata    (sdata),
		.sgate    (sgate)
	);

	complex_freq #(
		.refcnt_w (refcnt_w)
	) i_complex_freq (
		.clk        (clk),
		.rst_n      (rst_n),
		.sdata      (sdata),
		.sgate      (sgate),
		.freq       (freq),
		.freq_valid (freq_valid),
		.amp_max    (amp_max),
		.amp_min    (amp_min),
		.updated    (updated),
		.timing_err (timing_err)
	);

endmodule

//--- source/complex_freq.sv
`timescale 1ns/10ps

module complex_freq #(
	parameter int refcnt_w = cfreq_pkg::REFCNT_W_DEF
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cfreq_pkg::sample_t         sdata,
	input  logic                       sgate,      // Two cycles, I then Q
	output logic signed [refcnt_w-1:0] freq,
	output logic                       freq_valid,
	output cfreq_pkg::amp_t            amp_max,
	output cfreq_pkg::amp_t            amp_min,
	output logic                       updated,    // Pulse when results change
	output logic                       timing_err  // Sample arrived mid calculation
);

	logic signed [2*cfreq_pkg::SAMPLE_W-1:0] square;
	logic signed [2*cfreq_pkg::SAMPLE_W-1:0] square_d;
	logic [2*cfreq_pkg::SAMPLE_W:0]          square_sum;
	cfreq_pkg::square_t radicand;

	logic sgate_d1;
	logic sgate_d2;
	logic sum_valid;

	cfreq_pkg::amp_t root;
	logic            root_valid;
	logic            root_busy;

	logic [refcnt_w-1:0] refcnt;
	logic                rollover;
	logic                close_win;

	cfreq_pkg::amp_t amp_max_x; // Developing extremes
	cfreq_pkg::amp_t amp_min_x;

	logic [1:0]        quad;
	logic [1:0]        quad_prev;
	logic [1:0]        quad_step;
	logic [refcnt_w:0] quad_cnt;
	logic [refcnt_w:0] freq_cnt;
	logic              invalid;

	// Single multiplier, I squared and Q squared arrive on consecutive cycles
	always_ff @(posedge clk) begin
		square     <= sdata * sdata;
		square_d   <= square;
		square_sum <= {1'b0, square} + {1'b0, square_d};
	end

	assign radicand = square_sum[cfreq_pkg::SQ_W-1:0];

	// Sum is valid three cycles after the first gate cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sgate_d1  <= 1'b0;
			sgate_d2  <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			sgate_d1  <= sgate;
			sgate_d2  <= sgate_d1;
			sum_valid <= sgate_d1 & sgate_d2;
		end
	end

	isqrt i_isqrt (
		.clk   (clk),
		.rst_n (rst_n),
		.x     (radicand),
		.en    (sum_valid),
		.y     (root),
		.dav   (root_valid),
		.busy  (root_busy)
	);

	// Flag only, latching is up to the consumer
	always_ff @(posedge clk) begin
		if (!rst_n) timing_err <= 1'b0;
		else        timing_err <= root_busy & sgate;
	end

	// Window counter, first window is short and closes on sample 3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			refcnt   <= {{(refcnt_w-1){1'b0}}, 1'b1};
			rollover <= 1'b0;
		end else begin
			if (root_valid) refcnt <= refcnt - 1'b1;
			rollover <= &refcnt;
		end
	end

	assign close_win = root_valid & rollover;

	// Magnitude extremes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			amp_max_x <= '0;
			amp_min_x <= '1;
			amp_max   <= '0;
			amp_min   <= '0;
		end else if (root_valid) begin
			if (close_win || root > amp_max_x) amp_max_x <= root;
			if (close_win || root < amp_min_x) amp_min_x <= root;
			if (close_win) begin
				amp_max <= amp_max_x; // Freeze the finished window
				amp_min <= amp_min_x;
			end
		end
	end

	// Quadrant code is {sign I, sign I ^ sign Q}
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			quad <= 2'b00;
		end else if (sgate) begin
			if (sgate_d1) quad <= {quad[0], quad[0] ^ sdata[cfreq_pkg::SAMPLE_W-1]};
			else          quad <= {quad[1], sdata[cfreq_pkg::SAMPLE_W-1]}; // Park sign I
		end
	end

	assign quad_step = quad - quad_prev;

	// Quadrant crossing count and window report
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			quad_prev  <= 2'b00;
			quad_cnt   <= '0;
			invalid    <= 1'b0;
			freq_cnt   <= '0;
			freq_valid <= 1'b0;
			updated    <= 1'b0;
		end else begin
			if (sum_valid) begin
				quad_prev <= quad;
				case (quad_step)
					2'd1:    quad_cnt <= quad_cnt + 1'b1;
					2'd2:    invalid  <= 1'b1; // Jump is ambiguous in direction
					2'd3:    quad_cnt <= quad_cnt - 1'b1;
					default: quad_cnt <= quad_cnt;
				endcase
			end
			if (close_win) begin
				freq_cnt   <= quad_cnt;
				freq_valid <= ~invalid;
				quad_cnt   <= '0;
				invalid    <= 1'b0;
			end
			updated <= close_win;
		end
	end

	assign freq = freq_cnt[refcnt_w:1]; // Drop the lowest bit

endmodule

//--- source/isqrt.sv
`timescale 1ns/10ps

module isqrt (
	input  logic               clk,
	input  logic               rst_n,
	input  cfreq_pkg::square_t x,
	input  logic               en,
	output cfreq_pkg::amp_t    y,
	output logic               dav,
	output logic               busy
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DONE
	} state_t;

	state_t                   state;
	cfreq_pkg::square_t       x_sh;  // Radicand, consumed two bits per step
	logic [cfreq_pkg::AMP_W+1:0] rem; // Partial remainder
	logic [cfreq_pkg::AMP_W+1:0] rem_sh;
	logic [cfreq_pkg::AMP_W+1:0] trial;
	cfreq_pkg::amp_t          root;
	cfreq_pkg::amp_t          step;  // Walking one marks the last iteration

	// Bring down the next two radicand bits and try root*4+1
	assign rem_sh = {rem[cfreq_pkg::AMP_W-1:0], x_sh[cfreq_pkg::SQ_W-1 -: 2]};
	assign trial  = {root, 2'b01};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (en) state <= S_RUN;
				S_RUN:  if (step[cfreq_pkg::AMP_W-1]) state <= S_DONE;
				S_DONE: state <= en ? S_RUN : S_IDLE; // Back to back start allowed
				default: state <= S_IDLE;
			endcase
		end
	end

	// Datapath, one result bit per cycle in S_RUN
	always_ff @(posedge clk) begin
		if (en && state != S_RUN) begin
			x_sh <= x;
			rem  <= '0;
			root <= '0;
			step <= cfreq_pkg::amp_t'(1);
		end else if (state == S_RUN) begin
			x_sh <= x_sh << 2;
			step <= step << 1;
			if (rem_sh >= trial) begin
				rem  <= rem_sh - trial;
				root <= {root[cfreq_pkg::AMP_W-2:0], 1'b1};
			end else begin
				rem  <= rem_sh;
				root <= {root[cfreq_pkg::AMP_W-2:0], 1'b0};
			end
		end
	end

	assign y    = root;
	assign dav  = (state == S_DONE); // 18 cycles after en
	assign busy = (state == S_RUN);

endmodule

//--- source/iq_interleave.sv
`timescale 1ns/10ps

module iq_interleave (
	input  logic               clk,
	input  logic               rst_n,
	input  cfreq_pkg::sample_t i_data,
	input  cfreq_pkg::sample_t q_data,
	input  logic               iq_valid,
	output cfreq_pkg::sample_t sdata,
	output logic               sgate
);

	cfreq_pkg::sample_t q_hold; // Q word parked while I is on the stream
	logic               phase;  // High while the Q word is still owed

	// Gate and phase, a new pair always restarts the emission
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sgate <= 1'b0;
			phase <= 1'b0;
		end else if (iq_valid) begin
			sgate <= 1'b1;
			phase <= 1'b1;
		end else if (phase) begin
			sgate <= 1'b1; // Second gate cycle carries Q
			phase <= 1'b0;
		end else begin
			sgate <= 1'b0;
		end
	end

	// Sample word, I goes out first and Q follows one cycle later
	always_ff @(posedge clk) begin
		if (iq_valid) begin
			sdata  <= i_data;
			q_hold <= q_data;
		end else if (phase) begin
			sdata <= q_hold;
		end
	end

endmodule

//--- source/cfreq_pkg.sv
package cfreq_pkg;

	// Width of one signed I or Q word on the interleaved stream
	localparam int SAMPLE_W = 18;

	// Magnitude width, the integer root of the radicand
	localparam int AMP_W = 17;

	// Sum of squares truncated to this many bits before the root
	localparam int SQ_W = 34;

	// Window exponent, a window spans 2**REFCNT_W_DEF samples
	localparam int REFCNT_W_DEF = 17;

	// One signed I or Q sample
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Unsigned magnitude
	typedef logic [AMP_W-1:0] amp_t;

	// Radicand fed to the square root
	typedef logic [SQ_W-1:0] square_t;

endpackage
